// File: Makefile
# Verilator build and run for the fault-tolerant execute stage

VERILATOR ?= verilator
TOP       ?= tb_ft_ex_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary

SRCS := $(wildcard hw/*.sv hw/*.svh verif/*.sv) src.f
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/ex_alu.sv
/*
 * Single redundant ALU lane
 *   - add/sub, logic and shift operations
 *   - signed/unsigned less-than and equality compares
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_alu import ex_pkg::*; (
  input  alu_req_t  req_i,
  output alu_resp_t resp_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic [SHAMT_W-1:0]  shamt;
  logic [`EX_XLEN-1:0] sum;
  logic [`EX_XLEN-1:0] diff;
  logic                cmp;

  // Shift amount from the low bits of operand b
  assign shamt = req_i.op_b[SHAMT_W-1:0];

  // Shared adder outputs
  assign sum  = req_i.op_a + req_i.op_b;
  assign diff = req_i.op_a - req_i.op_b;

  ////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////

  always_comb begin
    cmp = 1'b0;
    case (req_i.op)
      ALU_SLT:  cmp = $signed(req_i.op_a) < $signed(req_i.op_b);
      ALU_SLTU: cmp = req_i.op_a < req_i.op_b;
      // Equality falls out of the subtractor
      ALU_EQ:   cmp = (diff == '0);
      ALU_NE:   cmp = (diff != '0);
      default:  cmp = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    resp_o.cmp = cmp;
    case (req_i.op)
      ALU_ADD: resp_o.result = sum;
      ALU_SUB: resp_o.result = diff;
      ALU_AND: resp_o.result = req_i.op_a & req_i.op_b;
      ALU_OR:  resp_o.result = req_i.op_a | req_i.op_b;
      ALU_XOR: resp_o.result = req_i.op_a ^ req_i.op_b;
      ALU_SLL: resp_o.result = req_i.op_a << shamt;
      ALU_SRL: resp_o.result = req_i.op_a >> shamt;
      // Arithmetic shift keeps the sign of operand a
      ALU_SRA: resp_o.result = $signed(req_i.op_a) >>> shamt;
      // Compare ops return the flag in bit 0
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE: begin
        resp_o.result = {{(`EX_XLEN-1){1'b0}}, cmp};
      end
      default: resp_o.result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/ex_config.svh
/*
 * Build-time configuration of the fault-tolerant execute stage
 *   - datapath and register address widths
 *   - number of redundant ALU lanes
 *   - fault counter width and permanent-fault threshold
 */

`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Datapath width of one ALU lane
`define EX_XLEN 32

// Redundant lanes, three of them vote in any cycle
`define EX_NUM_LANES 4

// Register file address width, includes the FP/extra bank bit
`define EX_REGADDR_W 6

// Per-lane fault counter, saturates at all ones
`define FT_CNT_W 9

// Count at which a lane is treated as permanently faulty
`define FT_PERM_THRESHOLD 16

`endif

// File: hw/ex_pkg.sv
/*
 * Execute stage types
 *   - ALU opcode enum
 *   - per-lane ALU request and response structs
 *   - register write port struct for forward and write-back ports
 */

`default_nettype none

`include "ex_config.svh"

package ex_pkg;

  // ALU opcodes, shifts take the low bits of operand b
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB
  } alu_op_e;

  // One lane's copy of the operation
  typedef struct packed {
    alu_op_e             op;
    logic [`EX_XLEN-1:0] op_a;
    logic [`EX_XLEN-1:0] op_b;
  } alu_req_t;

  // Lane result, cmp mirrors bit 0 of result for compares
  typedef struct packed {
    logic [`EX_XLEN-1:0] result;
    logic                cmp;
  } alu_resp_t;

  // Register file write port
  typedef struct packed {
    logic                     we;
    logic [`EX_REGADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]      wdata;
  } fw_port_t;

endpackage

`default_nettype wire

// File: hw/ex_writeback.sv
/*
 * Execute stage write side
 *   - forward port mux between CSR data and voted ALU result
 *   - EX/WB register for the load write-back port
 *   - ex_ready / ex_valid stall logic
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ex_writeback import ex_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  alu_resp_t                voted_i,
  input  logic                     alu_en_i,
  input  logic                     csr_access_i,
  input  logic                     lsu_en_i,
  input  logic                     branch_in_ex_i,
  input  logic [`EX_XLEN-1:0]      csr_rdata_i,
  input  logic                     regfile_alu_we_i,
  input  logic [`EX_REGADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                     regfile_we_i,
  input  logic [`EX_REGADDR_W-1:0] regfile_waddr_i,
  input  logic [`EX_XLEN-1:0]      lsu_rdata_i,
  input  logic                     lsu_err_i,
  input  logic                     lsu_ready_ex_i,
  input  logic                     wb_ready_i,
  output fw_port_t                 fw_o,
  output fw_port_t                 wb_o,
  output logic                     ex_ready_o,
  output logic                     ex_valid_o
);

  logic                     stage_ready;
  logic                     ex_valid;
  logic                     wb_we_d;
  logic                     wb_we_q;
  logic [`EX_REGADDR_W-1:0] wb_waddr_q;

  ////////////////////////////////////////////////////////////
  // Forward port
  ////////////////////////////////////////////////////////////

  always_comb begin
    fw_o.we    = regfile_alu_we_i;
    fw_o.waddr = regfile_alu_waddr_i;
    // CSR read data wins over the ALU result
    if (csr_access_i) begin
      fw_o.wdata = csr_rdata_i;
    end else if (alu_en_i) begin
      fw_o.wdata = voted_i.result;
    end else begin
      fw_o.wdata = '0;
    end
  end

  // Valid only when both the LSU and WB can accept
  assign stage_ready = lsu_ready_ex_i & wb_ready_i;
  assign ex_valid    = (alu_en_i | csr_access_i | lsu_en_i) & stage_ready;
  // Branches resolve here and need no write-back slot
  assign ex_ready_o  = stage_ready | branch_in_ex_i;
  assign ex_valid_o  = ex_valid;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  // Faulting loads never reach the register file
  assign wb_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid) begin
      wb_we_q <= wb_we_d;
    end else if (wb_ready_i) begin
      // WB drained with nothing new so the slot empties
      wb_we_q <= 1'b0;
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid && wb_we_d) begin
      wb_waddr_q <= regfile_waddr_i;
    end
  end

  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

`default_nettype wire

// File: hw/ft_ex_stage.sv
/*
 * Fault-tolerant execute stage top level
 *   - four redundant ALU lanes and the majority voter
 *   - per-lane fault monitor
 *   - forward / write-back ports and stall logic
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ft_ex_stage import ex_pkg::*; import ft_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  alu_req_t [`EX_NUM_LANES-1:0]   lane_req_i,
  input  lane_idx_t                      exclude_lane_i,
  input  logic                           alu_en_i,
  input  logic                           csr_access_i,
  input  logic                           lsu_en_i,
  input  logic                           branch_in_ex_i,
  input  logic [`EX_XLEN-1:0]            csr_rdata_i,
  input  logic                           regfile_alu_we_i,
  input  logic [`EX_REGADDR_W-1:0]       regfile_alu_waddr_i,
  input  logic                           regfile_we_i,
  input  logic [`EX_REGADDR_W-1:0]       regfile_waddr_i,
  input  logic [`EX_XLEN-1:0]            lsu_rdata_i,
  input  logic                           lsu_err_i,
  input  logic                           lsu_ready_ex_i,
  input  logic                           wb_ready_i,
  output fw_port_t                       fw_o,
  output fw_port_t                       wb_o,
  output logic                           branch_decision_o,
  output ft_status_t                     ft_status_o,
  output fault_cnt_t [`EX_NUM_LANES-1:0] fault_cnt_o,
  output lane_mask_t                     permanent_faulty_o,
  output lane_mask_t                     perm_event_o,
  output logic                           ex_ready_o,
  output logic                           ex_valid_o
);

  alu_resp_t [`EX_NUM_LANES-1:0] lane_resp;
  alu_resp_t                     voted;
  lane_mask_t                    lane_mismatch;

  ////////////////////////////////////////////////////////////
  // Redundant ALU lanes
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `EX_NUM_LANES; i++) begin : g_lane
    ex_alu u_alu (
      .req_i  (lane_req_i[i]),
      .resp_o (lane_resp[i])
    );
  end

  // Vote and fault tracking
  ft_voter u_voter (
    .lane_resp_i (lane_resp),
    .exclude_i   (exclude_lane_i),
    .alu_en_i    (alu_en_i),
    .voted_o     (voted),
    .status_o    (ft_status_o),
    .mismatch_o  (lane_mismatch)
  );

  ft_fault_monitor u_monitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .mismatch_i   (lane_mismatch),
    .fault_cnt_o  (fault_cnt_o),
    .permanent_o  (permanent_faulty_o),
    .perm_event_o (perm_event_o)
  );

  // Branch outcome from the voted compare
  assign branch_decision_o = voted.cmp;

  ex_writeback u_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .voted_i             (voted),
    .alu_en_i            (alu_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .lsu_err_i           (lsu_err_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .fw_o                (fw_o),
    .wb_o                (wb_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

`default_nettype wire

// File: hw/ft_fault_monitor.sv
/*
 * Per-lane fault bookkeeping
 *   - saturating mismatch counters
 *   - permanent-fault flags at the threshold
 *   - one-cycle event pulse when a lane turns permanent
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ft_fault_monitor import ft_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_n,
  input  lane_mask_t                        mismatch_i,
  output fault_cnt_t [`EX_NUM_LANES-1:0]    fault_cnt_o,
  output lane_mask_t                        permanent_o,
  output lane_mask_t                        perm_event_o
);

  fault_cnt_t [`EX_NUM_LANES-1:0] cnt_q;
  fault_cnt_t [`EX_NUM_LANES-1:0] cnt_d;
  lane_mask_t                     perm_q;
  lane_mask_t                     perm_d;
  lane_mask_t                     event_q;

  // Next count and permanent flag per lane
  always_comb begin
    for (int i = 0; i < `EX_NUM_LANES; i++) begin
      cnt_d[i] = cnt_q[i];
      // Stop at all ones
      if (mismatch_i[i] && (cnt_q[i] != '1)) begin
        cnt_d[i] = cnt_q[i] + fault_cnt_t'(1);
      end
      perm_d[i] = (cnt_d[i] >= fault_cnt_t'(`FT_PERM_THRESHOLD));
    end
  end

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      perm_q  <= '0;
      event_q <= '0;
    end else begin
      cnt_q   <= cnt_d;
      perm_q  <= perm_d;
      // Rising edge of the permanent flag, counters never go down
      event_q <= perm_d & ~perm_q;
    end
  end

  assign fault_cnt_o  = cnt_q;
  assign permanent_o  = perm_q;
  assign perm_event_o = event_q;

endmodule

`default_nettype wire

// File: hw/ft_pkg.sv
/*
 * Fault-tolerance types
 *   - lane index and per-lane mask
 *   - fault counter word
 *   - vote status flags
 */

`default_nettype none

`include "ex_config.svh"

package ft_pkg;

  // Index of the lane that sits out of the vote
  typedef logic [$clog2(`EX_NUM_LANES)-1:0] lane_idx_t;

  // One bit per redundant lane
  typedef logic [`EX_NUM_LANES-1:0] lane_mask_t;

  // Saturating per-lane fault count
  typedef logic [`FT_CNT_W-1:0] fault_cnt_t;

  // Vote outcome
  typedef struct packed {
    // At least one voting lane disagreed
    logic err_detected;
    // Exactly one lane disagreed, majority is trustworthy
    logic err_corrected;
  } ft_status_t;

endpackage

`default_nettype wire

// File: hw/ft_voter.sv
/*
 * Three-of-four majority voter
 *   - selects the three lanes around the excluded one
 *   - bitwise majority on result and cmp
 *   - per-lane mismatch and detected/corrected status
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module ft_voter import ex_pkg::*; import ft_pkg::*; (
  input  alu_resp_t [`EX_NUM_LANES-1:0] lane_resp_i,
  input  lane_idx_t                     exclude_i,
  input  logic                          alu_en_i,
  output alu_resp_t                     voted_o,
  output ft_status_t                    status_o,
  output lane_mask_t                    mismatch_o
);

  lane_idx_t  sel_a;
  lane_idx_t  sel_b;
  lane_idx_t  sel_c;
  alu_resp_t  vote_a;
  alu_resp_t  vote_b;
  alu_resp_t  vote_c;
  alu_resp_t  voted;
  lane_mask_t lane_diff;
  lane_mask_t mismatch;

  ////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////

  // The three lanes following the excluded one, wrapping modulo four
  assign sel_a = exclude_i + lane_idx_t'(1);
  assign sel_b = exclude_i + lane_idx_t'(2);
  assign sel_c = exclude_i + lane_idx_t'(3);

  assign vote_a = lane_resp_i[sel_a];
  assign vote_b = lane_resp_i[sel_b];
  assign vote_c = lane_resp_i[sel_c];

  // Bitwise 2-of-3 majority across the whole response word
  assign voted   = (vote_a & vote_b) | (vote_a & vote_c) | (vote_b & vote_c);
  assign voted_o = voted;

  ////////////////////////////////////////////////////////////
  // Mismatch detection
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `EX_NUM_LANES; i++) begin
      // Excluded lane never counts against itself
      lane_diff[i] = (lane_resp_i[i] != voted) && (lane_idx_t'(i) != exclude_i);
    end
  end

  // No ALU op in flight, nothing to report
  assign mismatch   = alu_en_i ? lane_diff : '0;
  assign mismatch_o = mismatch;

  // Any disagreement is detected
  assign status_o.err_detected  = (mismatch != '0);
  // Single disagreeing lane, majority holds
  assign status_o.err_corrected = (mismatch != '0) &&
                                  ((mismatch & (mismatch - lane_mask_t'(1))) == '0);

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/ex_pkg.sv
hw/ft_pkg.sv
hw/ex_alu.sv
hw/ft_voter.sv
hw/ft_fault_monitor.sv
hw/ex_writeback.sv
hw/ft_ex_stage.sv
verif/tb_ft_ex_stage.sv

// File: verif/tb_ft_ex_stage.sv
/*
 * Testbench for the fault-tolerant execute stage
 *   - clock, reset and falling-edge stimulus
 *   - reference ALU, vote, forward port and fault-monitor model
 *   - rising-edge checker with typed compare tasks
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_config.svh"

module tb_ft_ex_stage import ex_pkg::*; import ft_pkg::*; ();

  localparam int SAT_TIMEOUT = 1000;

  logic clk;
  logic rst_n;
  alu_req_t [3:0] lane_req;
  lane_idx_t exclude_lane;
  logic alu_en, csr_access, lsu_en, branch_in_ex;
  logic [31:0] csr_rdata, lsu_rdata;
  logic regfile_alu_we, regfile_we, lsu_err, lsu_ready_ex, wb_ready;
  logic [5:0] regfile_alu_waddr, regfile_waddr;
  fw_port_t fw_o, wb_o;
  logic branch_decision_o, ex_ready_o, ex_valid_o;
  ft_status_t ft_status_o;
  fault_cnt_t [3:0] fault_cnt_o;
  lane_mask_t permanent_faulty_o, perm_event_o;

  integer seed;
  string test_name;
  // Checker model state
  fault_cnt_t [3:0] exp_cnt;
  lane_mask_t exp_perm, exp_event, new_perm, exp_mm;
  logic exp_wb_we;
  logic [5:0] exp_wb_waddr;
  alu_resp_t [3:0] exp_lane;
  alu_resp_t exp_voted;
  ft_status_t exp_status;
  int ev_count;

  ft_ex_stage dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .lane_req_i          (lane_req),
    .exclude_lane_i      (exclude_lane),
    .alu_en_i            (alu_en),
    .csr_access_i        (csr_access),
    .lsu_en_i            (lsu_en),
    .branch_in_ex_i      (branch_in_ex),
    .csr_rdata_i         (csr_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_err_i           (lsu_err),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .wb_ready_i          (wb_ready),
    .fw_o                (fw_o),
    .wb_o                (wb_o),
    .branch_decision_o   (branch_decision_o),
    .ft_status_o         (ft_status_o),
    .fault_cnt_o         (fault_cnt_o),
    .permanent_faulty_o  (permanent_faulty_o),
    .perm_event_o        (perm_event_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic alu_resp_t ref_alu(input alu_req_t r);
    alu_resp_t o;
    o = '0;
    case (r.op)
      ALU_ADD: o.result = r.op_a + r.op_b;
      ALU_SUB: o.result = r.op_a - r.op_b;
      ALU_AND: o.result = r.op_a & r.op_b;
      ALU_OR:  o.result = r.op_a | r.op_b;
      ALU_XOR: o.result = r.op_a ^ r.op_b;
      ALU_SLL: o.result = r.op_a << r.op_b[4:0];
      ALU_SRL: o.result = r.op_a >> r.op_b[4:0];
      ALU_SRA: o.result = $signed(r.op_a) >>> r.op_b[4:0];
      ALU_SLT: o.cmp = $signed(r.op_a) < $signed(r.op_b);
      ALU_SLTU: o.cmp = r.op_a < r.op_b;
      ALU_EQ:  o.cmp = r.op_a == r.op_b;
      ALU_NE:  o.cmp = r.op_a != r.op_b;
      default: o = '0;
    endcase
    if (o.cmp) o.result = 32'd1;
    return o;
  endfunction

  // Majority by counting ones over the three voting lanes
  function automatic alu_resp_t ref_vote(input alu_resp_t [3:0] r, input lane_idx_t ex);
    alu_resp_t v;
    int ones;
    for (int b = 0; b < 33; b++) begin
      ones = 0;
      for (int i = 0; i < 4; i++) begin
        if (i != int'(ex) && r[i][b]) ones++;
      end
      v[b] = (ones >= 2);
    end
    return v;
  endfunction

  function automatic fw_port_t ref_fw(input alu_resp_t v);
    fw_port_t f;
    f.we = regfile_alu_we;
    f.waddr = regfile_alu_waddr;
    f.wdata = csr_access ? csr_rdata : (alu_en ? v.result : 32'd0);
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_value(input string what, input logic [63:0] e, input logic [63:0] a);
    $display("FAIL %s: %s expected %h actual %h", test_name, what, e, a);
    $display("SIMULATION FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic check_fw(input string what, input fw_port_t e, input fw_port_t a);
    if (e !== a) report_value(what, 64'(e), 64'(a));
  endtask

  task automatic check_resp(input string what, input alu_resp_t e, input alu_resp_t a);
    if (e !== a) report_value(what, 64'(e), 64'(a));
  endtask

  task automatic check_status(input string what, input ft_status_t e, input ft_status_t a);
    if (e !== a) report_value(what, 64'(e), 64'(a));
  endtask

  task automatic check_cnt(input string what, input fault_cnt_t e, input fault_cnt_t a);
    if (e !== a) report_value(what, 64'(e), 64'(a));
  endtask

  task automatic check_mask(input string what, input lane_mask_t e, input lane_mask_t a);
    if (e !== a) report_value(what, 64'(e), 64'(a));
  endtask

  task automatic check_bit(input string what, input logic e, input logic a);
    if (e !== a) report_value(what, 64'(e), 64'(a));
  endtask

  ////////////////////////////////////////////////////////////
  // Checker
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < 4; i++) exp_lane[i] = ref_alu(lane_req[i]);
      exp_voted = ref_vote(exp_lane, exclude_lane);
      for (int i = 0; i < 4; i++) begin
        exp_mm[i] = alu_en && (i != int'(exclude_lane)) && (exp_lane[i] != exp_voted);
      end
      exp_status.err_detected = (exp_mm != '0);
      exp_status.err_corrected = ($countones(exp_mm) == 1);
      check_fw("forward port", ref_fw(exp_voted), fw_o);
      check_bit("branch decision", exp_voted.cmp, branch_decision_o);
      if (alu_en && !csr_access) check_resp("voted", exp_voted, {fw_o.wdata, branch_decision_o});
      check_status("status", exp_status, ft_status_o);
      check_bit("ex_ready", (lsu_ready_ex & wb_ready) | branch_in_ex, ex_ready_o);
      check_bit("ex_valid", (alu_en | csr_access | lsu_en) & lsu_ready_ex & wb_ready,
                ex_valid_o);
      for (int i = 0; i < 4; i++) check_cnt("fault count", exp_cnt[i], fault_cnt_o[i]);
      check_mask("permanent", exp_perm, permanent_faulty_o);
      check_mask("perm event", exp_event, perm_event_o);
      check_bit("wb we", exp_wb_we, wb_o.we);
      if (exp_wb_we) check_cnt("wb waddr", fault_cnt_t'(exp_wb_waddr), fault_cnt_t'(wb_o.waddr));
      check_fw("wb wdata", {1'b0, 6'd0, lsu_rdata}, {1'b0, 6'd0, wb_o.wdata});
      if (perm_event_o[1]) ev_count++;
      // Advance the model across this edge
      for (int i = 0; i < 4; i++) begin
        if (exp_mm[i] && exp_cnt[i] != 9'd511) exp_cnt[i] = exp_cnt[i] + 9'd1;
        new_perm[i] = (exp_cnt[i] >= 9'(`FT_PERM_THRESHOLD));
      end
      exp_event = new_perm & ~exp_perm;
      exp_perm = new_perm;
      if ((alu_en | csr_access | lsu_en) & lsu_ready_ex & wb_ready) begin
        exp_wb_we = regfile_we & ~lsu_err;
        if (exp_wb_we) exp_wb_waddr = regfile_waddr;
      end else if (wb_ready) begin
        exp_wb_we = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // Same request on every lane
  task automatic set_request(input alu_op_e op);
    alu_req_t r;
    r.op = op;
    r.op_a = rand_word();
    r.op_b = rand_word();
    for (int i = 0; i < 4; i++) lane_req[i] = r;
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout in %s while waiting for %s", test_name, what);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  endtask

  initial begin
    int guard;
    seed = 32'hd62e_30b0;
    rst_n = 1'b0;
    lane_req = '0;
    exclude_lane = '0;
    {alu_en, csr_access, lsu_en, branch_in_ex} = '0;
    {csr_rdata, lsu_rdata, regfile_alu_waddr, regfile_waddr} = '0;
    {regfile_alu_we, regfile_we, lsu_err} = '0;
    lsu_ready_ex = 1'b1;
    wb_ready = 1'b1;
    exp_cnt = '0;
    {exp_perm, exp_event, exp_wb_we, exp_wb_waddr} = '0;
    ev_count = 0;
    test_name = "reset";
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    test_name = "identical lanes";
    alu_en = 1'b1;
    for (int op = 0; op < 12; op++) begin
      repeat (6) begin
        @(negedge clk);
        set_request(alu_op_e'(4'(op)));
        exclude_lane = lane_idx_t'(rand_word());
        regfile_alu_we = rand_bit();
        regfile_alu_waddr = 6'(rand_word());
      end
    end

    test_name = "single corrupted lane";
    @(negedge clk);
    exclude_lane = 2'd0;
    set_request(ALU_ADD);
    lane_req[1].op_a = lane_req[1].op_a ^ 32'h0000_0100;
    repeat (4) @(negedge clk);

    test_name = "double corruption";
    set_request(ALU_ADD);
    lane_req[2].op_a = lane_req[2].op_a ^ 32'h0000_0010;
    lane_req[3].op_b = lane_req[3].op_b ^ 32'h0001_0000;
    repeat (3) @(negedge clk);
    test_name = "excluded lane corruption";
    set_request(ALU_ADD);
    lane_req[0].op_a = ~lane_req[0].op_a;
    repeat (3) @(negedge clk);

    test_name = "permanent fault";
    ev_count = 0;
    set_request(ALU_ADD);
    lane_req[1].op_b = lane_req[1].op_b ^ 32'h8000_0000;
    guard = 0;
    while (fault_cnt_o[1] != 9'd511 && guard < SAT_TIMEOUT) begin
      @(negedge clk);
      guard++;
    end
    if (guard >= SAT_TIMEOUT) fail_timeout("counter saturation");
    repeat (5) @(negedge clk);
    check_cnt("perm event pulses", 9'd1, 9'(ev_count));

    test_name = "forward priority";
    repeat (30) begin
      @(negedge clk);
      set_request(alu_op_e'(4'(rand_word() % 12)));
      alu_en = rand_bit();
      csr_access = rand_bit();
      csr_rdata = rand_word();
    end

    test_name = "write-back";
    @(negedge clk);
    {alu_en, csr_access} = 2'b00;
    repeat (40) begin
      lsu_en = rand_bit();
      regfile_we = rand_bit();
      regfile_waddr = 6'(rand_word());
      lsu_err = rand_bit();
      lsu_rdata = rand_word();
      lsu_ready_ex = rand_bit();
      wb_ready = rand_bit();
      branch_in_ex = rand_bit();
      @(negedge clk);
    end

    // Clean load fills the slot
    {lsu_en, regfile_we, lsu_err, branch_in_ex} = 4'b1100;
    {lsu_ready_ex, wb_ready} = 2'b11;
    regfile_waddr = 6'h2a;
    @(negedge clk);
    // WB stalled so the slot keeps its write
    wb_ready = 1'b0;
    regfile_waddr = 6'h15;
    repeat (3) @(negedge clk);
    // Faulting load must not write
    wb_ready = 1'b1;
    lsu_err = 1'b1;
    @(negedge clk);
    {lsu_en, regfile_we, lsu_err, wb_ready, branch_in_ex} = 5'b11001;
    lsu_ready_ex = 1'b0;
    repeat (4) @(negedge clk);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
